// File: bus_arbiter.sv
module bus_arbiter
(
   input  logic        clk,
   input  logic        resetn,
   input  logic        brn,
   input  logic        bgackn,
   bus_slice_if.arb    slice_bus,
   output logic        bgn,
   output logic        bus_en
);

   bus_pkg::arb_state_t arb_state;
   bus_pkg::arb_state_t next_state;

   // ------------------------------
   // Next state decode
   // ------------------------------
   always_comb
   begin
      next_state = arb_state;
      case (arb_state)
         // Grant only between bus cycles
         bus_pkg::ARB_IDLE:
            if (!brn && slice_bus.slice == bus_pkg::S0S1)
               next_state = bus_pkg::ARB_GRANT;
         // Three-wire if BGACK answers, two-wire ends on BR release
         bus_pkg::ARB_GRANT:
            if (!bgackn)
               next_state = bus_pkg::ARB_WAIT_RELEASE;
            else if (brn)
               next_state = bus_pkg::ARB_IDLE;
         // Another master may re-enter right after release
         bus_pkg::ARB_WAIT_RELEASE:
            if (bgackn)
               next_state = brn ? bus_pkg::ARB_IDLE : bus_pkg::ARB_GRANT;
         default:
            next_state = bus_pkg::ARB_IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge resetn)
   begin
      if (!resetn)
         arb_state <= bus_pkg::ARB_IDLE;
      else
         arb_state <= next_state;
   end

   // A grant taken at this edge wins over a new cycle start
   assign slice_bus.arb_idle = (next_state == bus_pkg::ARB_IDLE) &&
                               (arb_state == bus_pkg::ARB_IDLE);
   assign bgn    = (arb_state != bus_pkg::ARB_GRANT);
   assign bus_en = (arb_state == bus_pkg::ARB_IDLE);

   // Slice counter must be parked when a grant begins
   a_grant_at_s0: assert property (
      @(posedge clk) disable iff (!resetn)
      (arb_state == bus_pkg::ARB_IDLE) ##1 (arb_state == bus_pkg::ARB_GRANT)
      |-> slice_bus.slice == bus_pkg::S0S1
   );

endmodule

// File: bus_cycle_ctrl.sv
module bus_cycle_ctrl
(
   input  logic        clk,
   input  logic        resetn,
   input  logic        dtackn,
   bus_slice_if.ctrl   slice_bus,
   output logic        bus_cyc_rdy
);

   // Either request level starts a cycle
   logic            request;
   bus_pkg::slice_t next_slice;

   assign request = slice_bus.rd_bus | slice_bus.wr_bus;

   // ------------------------------
   // Slice sequencing
   // ------------------------------

   // S4S5 repeats as wait states until DTACK comes back
   always_comb
   begin
      case (slice_bus.slice)
         bus_pkg::S0S1: next_slice = bus_pkg::S2S3;
         bus_pkg::S2S3: next_slice = bus_pkg::S4S5;
         bus_pkg::S4S5: next_slice = dtackn ? bus_pkg::S4S5 : bus_pkg::S6S7;
         default:       next_slice = bus_pkg::S0S1;
      endcase
   end

   // Held at S0S1 while idle or while the bus is granted away
   always_ff @(posedge clk or negedge resetn)
   begin
      if (!resetn)
      begin
         slice_bus.slice <= bus_pkg::S0S1;
      end
      else if (!request || !slice_bus.arb_idle)
      begin
         slice_bus.slice <= bus_pkg::S0S1;
      end
      else
      begin
         // S6S7 wraps to S0S1, a held request then restarts
         slice_bus.slice <= next_slice;
      end
   end

   // Ready for exactly the one clock spent in S6S7
   assign bus_cyc_rdy = (slice_bus.slice == bus_pkg::S6S7);

   // Core must never ask for a read and a write at once
   a_req_mutex: assert property (
      @(posedge clk) disable iff (!resetn)
      !(slice_bus.rd_bus && slice_bus.wr_bus)
   );

endmodule

// File: bus_golden.txt
# kind a0 byte_word op_size(0 byte,1 word,2 long) sel_lo sel_hi data waits
# exp_buffer_a exp_data_core_out, hex except waits
read  0 1 1 1 0 1234 0 00001234 1234
read  0 1 2 0 1 abcd 2 abcd1234 abcd
read  0 1 2 1 0 5678 1 abcd5678 5678
read  0 0 0 1 0 9a3c 0 0000009a 9a3c
read  1 0 0 1 0 9a3c 3 0000003c 9a3c
read  0 1 1 0 0 0f0f 1 0000003c 0f0f
write 0 1 1 0 0 5555 0 00000000 0000
write 1 0 0 0 0 00aa 2 00000000 0000
write 0 0 0 0 0 aa00 1 00000000 0000
arb2  0 1 1 1 0 c0de 1 0000c0de c0de
arb3  0 1 1 0 0 0000 0 00000000 0000
reset 0 1 1 0 0 0000 0 00000000 0000
read  0 1 2 0 1 beef 0 beefc0de beef

// File: bus_interface_top.sv
module bus_interface_top
(
   input  logic                          clk,
   input  logic                          resetn,
   input  logic                          rd_bus,
   input  logic                          wr_bus,
   input  logic                          dtackn,
   input  logic                          a0,
   input  logic                          byte_word,
   input  logic [bus_pkg::DATA_W-1:0]    data_in,
   input  bus_pkg::op_size_t             op_size,
   input  logic                          sel_buff_lo,
   input  logic                          sel_buff_hi,
   input  logic                          brn,
   input  logic                          bgackn,
   input  logic                          reset_en,
   output logic                          asn,
   output logic                          udsn,
   output logic                          ldsn,
   output logic                          rwn,
   output logic                          data_oe,
   output logic                          bus_cyc_rdy,
   output logic [bus_pkg::BUFFER_W-1:0]  buffer_a,
   output logic [bus_pkg::DATA_W-1:0]    data_core_out,
   output logic                          bgn,
   output logic                          bus_en,
   output logic                          reset_out_en,
   output logic                          reset_rdy
);

   // Shared slice and request levels
   bus_slice_if slice_bus ();

   assign slice_bus.rd_bus = rd_bus;
   assign slice_bus.wr_bus = wr_bus;

   // ------------------------------
   // Bus cycle path
   // ------------------------------
   bus_cycle_ctrl bus_cycle_ctrl_i (
      .clk         (clk),
      .resetn      (resetn),
      .dtackn      (dtackn),
      .slice_bus   (slice_bus.ctrl),
      .bus_cyc_rdy (bus_cyc_rdy)
   );

   bus_strobe_gen bus_strobe_gen_i (
      .slice_bus (slice_bus.strobe),
      .a0        (a0),
      .byte_word (byte_word),
      .asn       (asn),
      .udsn      (udsn),
      .ldsn      (ldsn),
      .rwn       (rwn),
      .data_oe   (data_oe)
   );

   read_capture read_capture_i (
      .clk           (clk),
      .resetn        (resetn),
      .slice_bus     (slice_bus.capture),
      .data_in       (data_in),
      .a0            (a0),
      .op_size       (op_size),
      .sel_buff_lo   (sel_buff_lo),
      .sel_buff_hi   (sel_buff_hi),
      .buffer_a      (buffer_a),
      .data_core_out (data_core_out)
   );

   // ------------------------------
   // Arbitration and reset command
   // ------------------------------
   bus_arbiter bus_arbiter_i (
      .clk       (clk),
      .resetn    (resetn),
      .brn       (brn),
      .bgackn    (bgackn),
      .slice_bus (slice_bus.arb),
      .bgn       (bgn),
      .bus_en    (bus_en)
   );

   reset_cmd_timer reset_cmd_timer_i (
      .clk          (clk),
      .resetn       (resetn),
      .reset_en     (reset_en),
      .reset_out_en (reset_out_en),
      .reset_rdy    (reset_rdy)
   );

endmodule

// File: bus_pkg.sv
package bus_pkg;

   // ------------------------------
   // Bus timing types
   // ------------------------------

   // Four phases of a bus cycle, two clock halves each
   typedef enum logic [1:0]
   {
      S0S1 = 2'd0,
      S2S3 = 2'd1,
      S4S5 = 2'd2,
      S6S7 = 2'd3
   } slice_t;

   // Arbitration states, two- and three-wire
   typedef enum logic [1:0]
   {
      ARB_IDLE         = 2'd0,
      ARB_GRANT        = 2'd1,
      ARB_WAIT_RELEASE = 2'd2
   } arb_state_t;

   // Operand size from the core
   typedef enum logic [1:0]
   {
      SIZE_BYTE = 2'd0,
      SIZE_WORD = 2'd1,
      SIZE_LONG = 2'd2
   } op_size_t;

   // ------------------------------
   // Widths and timer constants
   // ------------------------------
   localparam int DATA_W = 16;
   localparam int BUFFER_W = 32;
   // Length of the reset command in clocks
   localparam logic [6:0] RESET_CYCLES = 7'd124;
   // Final counts with the reset output already released
   localparam logic [6:0] RESET_OUT_TAIL = 7'd3;

endpackage

// File: bus_slice_if.sv
interface bus_slice_if;

   // Current phase of the bus cycle
   bus_pkg::slice_t slice;
   // Request levels from the core
   logic rd_bus;
   logic wr_bus;
   // Arbiter stays idle through the coming edge
   logic arb_idle;

   // Slice counter owner
   modport ctrl (output slice, input rd_bus, input wr_bus, input arb_idle);
   // Arbitration machine
   modport arb (output arb_idle, input slice);
   // Strobe decode
   modport strobe (input slice, input rd_bus, input wr_bus);
   // Read data sampling
   modport capture (input slice, input rd_bus);

endinterface

// File: bus_strobe_gen.sv
module bus_strobe_gen
(
   bus_slice_if.strobe slice_bus,
   input  logic        a0,
   input  logic        byte_word,
   output logic        asn,
   output logic        udsn,
   output logic        ldsn,
   output logic        rwn,
   output logic        data_oe
);

   // Slice is only left at S0S1 during an active cycle
   logic cyc_active;
   // Data strobe window for the current cycle type
   logic ds_active;
   // Byte lane enables
   logic upper_lane;
   logic lower_lane;

   assign cyc_active = (slice_bus.slice != bus_pkg::S0S1);

   // ------------------------------
   // Strobe windows
   // ------------------------------

   // Read strobes open at S2S3, write strobes wait until S4S5
   // so that the data is already on the bus
   assign ds_active = (slice_bus.slice == bus_pkg::S4S5) ||
                      (slice_bus.slice == bus_pkg::S6S7) ||
                      (slice_bus.slice == bus_pkg::S2S3 && slice_bus.rd_bus);

   // Word access uses both lanes, a byte goes by a0
   assign upper_lane = byte_word | ~a0;
   assign lower_lane = byte_word | a0;

   // ------------------------------
   // Active low bus outputs
   // ------------------------------
   assign asn  = ~cyc_active;
   assign udsn = ~(ds_active & upper_lane);
   assign ldsn = ~(ds_active & lower_lane);

   // Write direction for the whole cycle
   assign rwn = ~(cyc_active & slice_bus.wr_bus);

   // Drive data ahead of the write strobes
   assign data_oe = slice_bus.wr_bus &&
                    (slice_bus.slice == bus_pkg::S2S3 ||
                     slice_bus.slice == bus_pkg::S4S5);

endmodule

// File: read_capture.sv
module read_capture
(
   input  logic                          clk,
   input  logic                          resetn,
   bus_slice_if.capture                  slice_bus,
   input  logic [bus_pkg::DATA_W-1:0]    data_in,
   input  logic                          a0,
   input  bus_pkg::op_size_t             op_size,
   input  logic                          sel_buff_lo,
   input  logic                          sel_buff_hi,
   output logic [bus_pkg::BUFFER_W-1:0]  buffer_a,
   output logic [bus_pkg::DATA_W-1:0]    data_core_out
);

   // Cycle type noted in S2S3, the core may drop rd_bus during S6S7
   logic                rd_cyc;
   // Addressed byte of the data bus
   logic [7:0]          rd_byte;

   // Even address on the upper lane, odd on the lower
   assign rd_byte = a0 ? data_in[7:0] : data_in[bus_pkg::DATA_W-1 -: 8];

   always_ff @(posedge clk or negedge resetn)
   begin
      if (!resetn)
      begin
         rd_cyc        <= 1'b0;
         buffer_a      <= '0;
         data_core_out <= '0;
      end
      else
      begin
         if (slice_bus.slice == bus_pkg::S2S3)
            rd_cyc <= slice_bus.rd_bus;
         // Data valid at the end of S6S7
         if (slice_bus.slice == bus_pkg::S6S7 && rd_cyc)
         begin
            // Transparent copy of the bus word
            data_core_out <= data_in;
            if (sel_buff_lo && op_size == bus_pkg::SIZE_BYTE)
               buffer_a <= {{(bus_pkg::BUFFER_W-8){1'b0}}, rd_byte};
            else if (sel_buff_lo)
               buffer_a[bus_pkg::DATA_W-1:0] <= data_in;
            // Upper word of a long operand
            else if (sel_buff_hi)
               buffer_a[bus_pkg::BUFFER_W-1 -: bus_pkg::DATA_W] <= data_in;
         end
      end
   end

endmodule

// File: reset_cmd_timer.sv
module reset_cmd_timer
(
   input  logic clk,
   input  logic resetn,
   input  logic reset_en,
   output logic reset_out_en,
   output logic reset_rdy
);

   // Down counter of the reset command
   logic [$bits(bus_pkg::RESET_CYCLES)-1:0] reset_count;
   // Blocks a reload while reset_en stays high
   logic                                    reset_lock;

   always_ff @(posedge clk or negedge resetn)
   begin
      if (!resetn)
      begin
         reset_count <= '0;
         reset_lock  <= 1'b0;
         reset_rdy   <= 1'b0;
      end
      else
      begin
         if (reset_en && !reset_lock)
         begin
            reset_count <= bus_pkg::RESET_CYCLES;
            reset_lock  <= 1'b1;
         end
         else if (reset_count != '0)
            reset_count <= reset_count - 1'b1;
         // Unlock only after the command finished
         else if (!reset_en)
            reset_lock <= 1'b0;
         // Strobe as the count reaches zero
         reset_rdy <= (reset_count == 1);
      end
   end

   // Reset output released for the last few counts
   assign reset_out_en = (reset_count > bus_pkg::RESET_OUT_TAIL);

   // Ready is a single clock strobe
   a_rdy_pulse: assert property (
      @(posedge clk) disable iff (!resetn)
      reset_rdy |=> !reset_rdy
   );

endmodule

// File: run.sh
#!/bin/sh
# Build and run the bus interface testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_bus_interface -f tb.f
out=$(./obj_dir/Vtb_bus_interface)
echo "$out"
echo "$out" | grep -qx "TESTS PASSED"

// File: tb.f
bus_pkg.sv
bus_slice_if.sv
bus_cycle_ctrl.sv
bus_strobe_gen.sv
read_capture.sv
bus_arbiter.sv
reset_cmd_timer.sv
bus_interface_top.sv
tb_bus_interface.sv

// File: tb_bus_interface.sv
module tb_bus_interface;

   logic                         clk = 1'b0;
   logic                         resetn;
   logic                         rd_bus;
   logic                         wr_bus;
   logic                         dtackn;
   logic                         a0;
   logic                         byte_word;
   logic [bus_pkg::DATA_W-1:0]   data_in;
   bus_pkg::op_size_t            op_size;
   logic                         sel_buff_lo;
   logic                         sel_buff_hi;
   logic                         brn;
   logic                         bgackn;
   logic                         reset_en;
   logic                         asn;
   logic                         udsn;
   logic                         ldsn;
   logic                         rwn;
   logic                         data_oe;
   logic                         bus_cyc_rdy;
   logic [bus_pkg::BUFFER_W-1:0] buffer_a;
   logic [bus_pkg::DATA_W-1:0]   data_core_out;
   logic                         bgn;
   logic                         bus_en;
   logic                         reset_out_en;
   logic                         reset_rdy;

   // Golden table, one entry per transaction line
   logic [95:0] kind_q [0:31];
   logic        a0_q [0:31];
   logic        bw_q [0:31];
   logic [1:0]  size_q [0:31];
   logic        lo_q [0:31];
   logic        hi_q [0:31];
   logic [15:0] data_q [0:31];
   int          waits_q [0:31];
   logic [31:0] exp_buf_q [0:31];
   logic [15:0] exp_data_q [0:31];
   int          n_tests = 0;
   int          err_count = 0;
   bit          loaded = 1'b0;

   always #4 clk = ~clk;

   bus_interface_top bus_interface_top_i (.*);

   // ------------------------------
   // Compare helpers
   // ------------------------------
   task automatic check_bit(input string name, input logic got, input logic exp);
      assert (got === exp)
      else
      begin
         $display("Error: time %0t, signal %s is %b, expected %b", $time, name, got, exp);
         err_count++;
      end
   endtask

   task automatic check_word(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
      assert (got === exp)
      else
      begin
         $display("Error: time %0t, signal %s is %h, expected %h", $time, name, got, exp);
         err_count++;
      end
   endtask

   // One bus cycle with a DTACK responder, optional bus request mid-cycle
   task automatic run_cycle(input bit is_wr, input int i, input bit br_mid);
      int   k;
      int   idle;
      int   last;
      logic ds;
      last = 3 + waits_q[i];
      k = 0;
      idle = 0;
      a0 = a0_q[i];
      byte_word = bw_q[i];
      op_size = bus_pkg::op_size_t'(size_q[i]);
      sel_buff_lo = lo_q[i];
      sel_buff_hi = hi_q[i];
      data_in = data_q[i];
      rd_bus = !is_wr;
      wr_bus = is_wr;
      dtackn = 1'b1;
      while (k < last && idle < 20)
      begin
         @(negedge clk);
         // Cycle may be held back by a grant still in progress
         if (asn === 1'b1 && k == 0)
            idle++;
         else
         begin
            k++;
            // Write strobes wait for S4S5
            ds = is_wr ? (k >= 2) : 1'b1;
            check_bit("asn", asn, 1'b0);
            check_bit("udsn", udsn, !(ds && (bw_q[i] || !a0_q[i])));
            check_bit("ldsn", ldsn, !(ds && (bw_q[i] || a0_q[i])));
            check_bit("rwn", rwn, !is_wr);
            check_bit("data_oe", data_oe, is_wr && (k < last));
            check_bit("bus_cyc_rdy", bus_cyc_rdy, k == last);
            check_bit("bgn", bgn, 1'b1);
            if (br_mid && k == 1)
               brn = 1'b0;
            // DTACK held off for the wait count once in S4S5
            dtackn = (k < 2 + waits_q[i]);
         end
      end
      if (idle >= 20)
      begin
         $display("Error: time %0t, no bus cycle started within 20 clocks", $time);
         err_count++;
      end
      rd_bus = 1'b0;
      wr_bus = 1'b0;
      dtackn = 1'b1;
      @(negedge clk);
      check_bit("asn", asn, 1'b1);
      check_bit("bus_cyc_rdy", bus_cyc_rdy, 1'b0);
      if (!is_wr)
      begin
         check_word("data_core_out", {16'h0, data_core_out}, {16'h0, exp_data_q[i]});
         check_word("buffer_a", buffer_a, exp_buf_q[i]);
      end
   endtask

   task automatic wait_grant();
      int n;
      n = 0;
      while (bgn !== 1'b0 && n < 10)
      begin
         @(negedge clk);
         n++;
      end
      if (bgn !== 1'b0)
      begin
         $display("Error: time %0t, bus grant not given within 10 clocks", $time);
         err_count++;
      end
      check_bit("bus_en", bus_en, 1'b0);
   endtask

   // ------------------------------
   // Arbitration and reset tests
   // ------------------------------
   task automatic run_two_wire(input int i);
      run_cycle(1'b0, i, 1'b1);
      wait_grant();
      // Request while granted away must not start a cycle
      rd_bus = 1'b1;
      repeat (4)
      begin
         @(negedge clk);
         check_bit("asn", asn, 1'b1);
         check_bit("bgn", bgn, 1'b0);
      end
      brn = 1'b1;
      @(negedge clk);
      check_bit("bgn", bgn, 1'b1);
      check_bit("bus_en", bus_en, 1'b1);
      run_cycle(1'b0, i, 1'b0);
   endtask

   task automatic run_three_wire();
      brn = 1'b0;
      wait_grant();
      // New master acknowledges and drops its request
      bgackn = 1'b0;
      brn = 1'b1;
      repeat (2)
      begin
         @(negedge clk);
         check_bit("bgn", bgn, 1'b1);
         check_bit("bus_en", bus_en, 1'b0);
      end
      bgackn = 1'b1;
      @(negedge clk);
      check_bit("bgn", bgn, 1'b1);
      check_bit("bus_en", bus_en, 1'b1);
   endtask

   task automatic run_reset_cmd();
      int j;
      // reset_en stays high past the strobe, lock must hold
      reset_en = 1'b1;
      for (j = 0; j < 160; j++)
      begin
         @(negedge clk);
         check_bit("reset_out_en", reset_out_en, j < 121);
         check_bit("reset_rdy", reset_rdy, j == 124);
      end
      reset_en = 1'b0;
      @(negedge clk);
   endtask

   // Watchdog sized from the golden table
   initial
   begin
      wait (loaded);
      repeat (n_tests * 200 + 500) @(posedge clk);
      $display("Error: watchdog expired before the tests finished");
      $display("TESTS FAILED");
      $finish;
   end

   initial
   begin
      int    fd;
      int    code;
      int    nf;
      int    i;
      int    errs_before;
      int    n_failed;
      string line;
      logic [95:0] kind_v;
      logic  a0_v;
      logic  bw_v;
      logic  lo_v;
      logic  hi_v;
      logic [1:0]  size_v;
      logic [15:0] data_v;
      logic [15:0] exp_data_v;
      logic [31:0] exp_buf_v;
      int    waits_v;
      n_failed = 0;
      resetn = 1'b0;
      rd_bus = 1'b0;
      wr_bus = 1'b0;
      dtackn = 1'b1;
      a0 = 1'b0;
      byte_word = 1'b1;
      data_in = '0;
      op_size = bus_pkg::SIZE_WORD;
      sel_buff_lo = 1'b0;
      sel_buff_hi = 1'b0;
      brn = 1'b1;
      bgackn = 1'b1;
      reset_en = 1'b0;
      fd = $fopen("bus_golden.txt", "r");
      if (fd == 0)
      begin
         $display("Error: cannot open bus_golden.txt");
         $display("TESTS FAILED");
         $finish;
      end
      else
      begin
         while (!$feof(fd))
         begin
            line = "";
            code = $fgets(line, fd);
            if (code != 0 && line[0] != "#")
            begin
               nf = $sscanf(line, "%s %h %h %h %h %h %h %d %h %h", kind_v, a0_v, bw_v,
                            size_v, lo_v, hi_v, data_v, waits_v, exp_buf_v, exp_data_v);
               if (nf == 10 && n_tests < 32)
               begin
                  kind_q[n_tests] = kind_v;
                  a0_q[n_tests] = a0_v;
                  bw_q[n_tests] = bw_v;
                  size_q[n_tests] = size_v;
                  lo_q[n_tests] = lo_v;
                  hi_q[n_tests] = hi_v;
                  data_q[n_tests] = data_v;
                  waits_q[n_tests] = waits_v;
                  exp_buf_q[n_tests] = exp_buf_v;
                  exp_data_q[n_tests] = exp_data_v;
                  n_tests++;
               end
            end
         end
         $fclose(fd);
         loaded = 1'b1;
         repeat (5) @(negedge clk);
         resetn = 1'b1;
         @(negedge clk);
         // Everything inactive out of reset
         check_bit("asn", asn, 1'b1);
         check_bit("udsn", udsn, 1'b1);
         check_bit("ldsn", ldsn, 1'b1);
         check_bit("rwn", rwn, 1'b1);
         check_bit("data_oe", data_oe, 1'b0);
         check_bit("bus_cyc_rdy", bus_cyc_rdy, 1'b0);
         check_bit("bgn", bgn, 1'b1);
         check_bit("bus_en", bus_en, 1'b1);
         check_bit("reset_out_en", reset_out_en, 1'b0);
         check_bit("reset_rdy", reset_rdy, 1'b0);
         for (i = 0; i < n_tests; i++)
         begin
            errs_before = err_count;
            if (kind_q[i] == "read")
               run_cycle(1'b0, i, 1'b0);
            else if (kind_q[i] == "write")
               run_cycle(1'b1, i, 1'b0);
            else if (kind_q[i] == "arb2")
               run_two_wire(i);
            else if (kind_q[i] == "arb3")
               run_three_wire();
            else if (kind_q[i] == "reset")
               run_reset_cmd();
            else
            begin
               $display("Error: unknown transaction kind on golden line %0d", i + 1);
               err_count++;
            end
            if (err_count != errs_before)
            begin
               n_failed++;
               $display("Test %0d %0s: failed", i + 1, kind_q[i]);
            end
            else
               $display("Test %0d %0s: ok", i + 1, kind_q[i]);
         end
         $display("%0d tests run, %0d failed, %0d errors", n_tests, n_failed, err_count);
         if (err_count == 0)
            $display("TESTS PASSED");
         else
            $display("TESTS FAILED");
         $finish;
      end
   end

endmodule
